// File: compile.f
+incdir+include
hw/mipsCtrlPkg.sv
hw/instrDecoder.sv
hw/stepSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
tests/controlUnit_sva.sv
tests/controlUnitTb.sv

// File: hw/controlUnit.sv
`timescale 1ns/10ps
`include "mipsCtrl_config.svh"

module controlUnit (
  input  logic                   clk,
  input  logic                   reset_in,
  input  logic [`OPCODE_W-1:0]   opcode,
  input  logic [`FUNCT_W-1:0]    funct,
  output mipsCtrlPkg::ctrlWord_t ctrl,
  output logic                   datapathReset
);

  mipsCtrlPkg::decodedInstr_t decoded;
  mipsCtrlPkg::seqState_t     seq;

  instrDecoder decoder_inst (
    .opcode  (opcode),
    .funct   (funct),
    .decoded (decoded)
  );

  stepSequencer sequencer_inst (
    .clk      (clk),
    .reset_in (reset_in),
    .decoded  (decoded),
    .seq      (seq)
  );

  controlWordGen wordGen_inst (
    .seq           (seq),
    .ctrl          (ctrl),
    .datapathReset (datapathReset)
  );

endmodule

// File: hw/controlWordGen.sv
`timescale 1ns/10ps

module controlWordGen (
  input  mipsCtrlPkg::seqState_t seq,
  output mipsCtrlPkg::ctrlWord_t ctrl,
  output logic                   datapathReset
);

  mipsCtrlPkg::instrClass_e cls;
  logic                     opWindow; // Execute steps 1 and 2
  logic                     varWindow; // Execute steps 1 to 3

  assign cls       = seq.instr.instrClass;
  assign opWindow  = (seq.step == 3'd1) || (seq.step == 3'd2);
  assign varWindow = opWindow || (seq.step == 3'd3);

  assign datapathReset = (seq.phase == mipsCtrlPkg::reset);

  always_comb begin
    ctrl = '0;

    case (seq.phase)
      mipsCtrlPkg::fetch: begin
        case (seq.step)
          3'd0: begin // PC+4 into ALUOut, instruction into IR
            ctrl.irWrite     = 1'b1;
            ctrl.aluSrcA     = mipsCtrlPkg::pc;
            ctrl.aluSrcB     = mipsCtrlPkg::four;
            ctrl.aluOp       = mipsCtrlPkg::add;
            ctrl.aluOutWrite = 1'b1;
          end
          3'd2: begin
            ctrl.pcWrite = 1'b1;
            ctrl.pcSrc   = mipsCtrlPkg::pcAluOut;
            case (cls)
              mipsCtrlPkg::jump: ctrl.pcSrc = mipsCtrlPkg::pcJumpTarget;
              mipsCtrlPkg::jumpLink: begin
                ctrl.pcSrc    = mipsCtrlPkg::pcJumpTarget;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = mipsCtrlPkg::ra;
                ctrl.regData  = mipsCtrlPkg::pcLink; // Return address
              end
              mipsCtrlPkg::rte: ctrl.pcSrc = mipsCtrlPkg::pcEpc;
              mipsCtrlPkg::moveHiLo: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = mipsCtrlPkg::rd;
                ctrl.regData  = seq.instr.selHi ? mipsCtrlPkg::hi : mipsCtrlPkg::lo;
              end
              default: ;
            endcase
          end
          default: ; // Memory read settles
        endcase
      end

      mipsCtrlPkg::execute: begin
        case (cls)
          mipsCtrlPkg::aluReg: begin
            ctrl.aWrite = (seq.step == 3'd0);
            ctrl.bWrite = (seq.step == 3'd0);
            if (opWindow) begin
              ctrl.aluSrcA = mipsCtrlPkg::regA;
              ctrl.aluSrcB = mipsCtrlPkg::regB;
              ctrl.aluOp   = seq.instr.aluOp;
            end
            if (seq.step == 3'd2) begin
              ctrl.regWrite = 1'b1;
              ctrl.regDst   = mipsCtrlPkg::rd;
              ctrl.regData  = mipsCtrlPkg::aluOut;
            end
          end
          mipsCtrlPkg::shiftVar: begin
            ctrl.aWrite = (seq.step == 3'd0);
            ctrl.bWrite = (seq.step == 3'd0);
            if (varWindow) begin // Shifter needs the extra cycle
              ctrl.aluSrcA = mipsCtrlPkg::regA;
              ctrl.aluSrcB = mipsCtrlPkg::regB;
              ctrl.aluOp   = seq.instr.aluOp;
            end
            if (seq.step == 3'd3) begin
              ctrl.regWrite = 1'b1;
              ctrl.regDst   = mipsCtrlPkg::rd;
              ctrl.regData  = mipsCtrlPkg::aluOut;
            end
          end
          mipsCtrlPkg::shiftImm: begin
            ctrl.bWrite = (seq.step == 3'd0);
            if (opWindow) begin
              ctrl.aluSrcB = mipsCtrlPkg::regB;
              ctrl.aluOp   = seq.instr.aluOp;
            end
            if (seq.step == 3'd2) begin
              ctrl.regWrite = 1'b1;
              ctrl.regDst   = mipsCtrlPkg::rd;
              ctrl.regData  = mipsCtrlPkg::aluOut;
            end
          end
          mipsCtrlPkg::jr: begin
            ctrl.aWrite = (seq.step == 3'd0);
            if (opWindow) begin
              ctrl.aluSrcA = mipsCtrlPkg::regA;
              ctrl.aluOp   = seq.instr.aluOp;
            end
            if (seq.step == 3'd2) begin
              ctrl.pcWrite = 1'b1;
              ctrl.pcSrc   = mipsCtrlPkg::pcAluResult;
            end
          end
          mipsCtrlPkg::brk: begin
            if (seq.step == 3'd0) begin // PC back to the break itself
              ctrl.aluSrcA     = mipsCtrlPkg::pc;
              ctrl.aluSrcB     = mipsCtrlPkg::four;
              ctrl.aluOp       = seq.instr.aluOp;
              ctrl.aluOutWrite = 1'b1;
            end
            if (seq.step == 3'd2) begin
              ctrl.pcWrite = 1'b1;
              ctrl.pcSrc   = mipsCtrlPkg::pcAluOut;
            end
          end
          default: ; // moveHiLo waits out its register write
        endcase
      end

      default: ;
    endcase
  end

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/10ps
`include "mipsCtrl_config.svh"

module instrDecoder (
  input  logic [`OPCODE_W-1:0]       opcode,
  input  logic [`FUNCT_W-1:0]        funct,
  output mipsCtrlPkg::decodedInstr_t decoded
);

  always_comb begin
    decoded.instrClass = mipsCtrlPkg::unsupported;
    decoded.aluOp      = mipsCtrlPkg::passA;
    decoded.selHi      = 1'b0;
    decoded.execSteps  = `EXEC_NONE;

    case (opcode)
      `OP_J:   decoded.instrClass = mipsCtrlPkg::jump;
      `OP_JAL: decoded.instrClass = mipsCtrlPkg::jumpLink;
      `OP_RTYPE: begin
        case (funct)
          `FN_ADD, `FN_SUB, `FN_AND, `FN_SLT: begin
            decoded.instrClass = mipsCtrlPkg::aluReg;
            decoded.execSteps  = `EXEC_ALU_REG;
            case (funct)
              `FN_ADD: decoded.aluOp = mipsCtrlPkg::add;
              `FN_SUB: decoded.aluOp = mipsCtrlPkg::sub;
              `FN_AND: decoded.aluOp = mipsCtrlPkg::andOp;
              default: decoded.aluOp = mipsCtrlPkg::slt;
            endcase
          end
          `FN_SLLV, `FN_SRAV: begin
            decoded.instrClass = mipsCtrlPkg::shiftVar;
            decoded.execSteps  = `EXEC_SHIFT_VAR;
            decoded.aluOp      = (funct == `FN_SLLV) ? mipsCtrlPkg::shiftL2
                                                     : mipsCtrlPkg::shiftRa2;
          end
          `FN_SLL, `FN_SRL, `FN_SRA: begin
            decoded.instrClass = mipsCtrlPkg::shiftImm;
            decoded.execSteps  = `EXEC_SHIFT_IMM;
            case (funct)
              `FN_SLL: decoded.aluOp = mipsCtrlPkg::shiftL1;
              `FN_SRL: decoded.aluOp = mipsCtrlPkg::shiftR;
              default: decoded.aluOp = mipsCtrlPkg::shiftRa1;
            endcase
          end
          `FN_JR: begin
            decoded.instrClass = mipsCtrlPkg::jr;
            decoded.execSteps  = `EXEC_JR; // Target passes straight through ALU
          end
          `FN_BREAK: begin
            decoded.instrClass = mipsCtrlPkg::brk;
            decoded.aluOp      = mipsCtrlPkg::sub; // Undo PC+4
            decoded.execSteps  = `EXEC_BREAK;
          end
          `FN_MFHI, `FN_MFLO: begin
            decoded.instrClass = mipsCtrlPkg::moveHiLo;
            decoded.selHi      = (funct == `FN_MFHI);
            decoded.execSteps  = `EXEC_MOVE_HILO;
          end
          `FN_RTE: decoded.instrClass = mipsCtrlPkg::rte;
          default: decoded.instrClass = mipsCtrlPkg::unsupported;
        endcase
      end
      default: decoded.instrClass = mipsCtrlPkg::unsupported; // I-type and the rest
    endcase
  end

endmodule

// File: hw/mipsCtrlPkg.sv
package mipsCtrlPkg;

  // ALU encoding, full set kept even where unused
  typedef enum logic [3:0] {
    passA    = 4'd0,
    add      = 4'd1,
    sub      = 4'd2,
    andOp    = 4'd3,
    passB    = 4'd4,
    shiftL1  = 4'd5,
    shiftL2  = 4'd6,
    shiftR   = 4'd7,
    shiftRa1 = 4'd8,
    shiftRa2 = 4'd9,
    slt      = 4'd10,
    beq      = 4'd11,
    bne      = 4'd12,
    ble      = 4'd13,
    bgt      = 4'd14,
    lui      = 4'd15
  } aluOp_e;

  typedef enum logic [3:0] {
    aluReg, shiftVar, shiftImm, jr, rte, moveHiLo, brk, jump, jumpLink, unsupported
  } instrClass_e;

  typedef enum logic [1:0] {
    pcAluResult  = 2'b00,
    pcAluOut     = 2'b01,
    pcJumpTarget = 2'b10,
    pcEpc        = 2'b11
  } pcSrc_e;

  typedef enum logic {pc = 1'b0, regA = 1'b1} aluSrcA_e;
  typedef enum logic {regB = 1'b0, four = 1'b1} aluSrcB_e;

  typedef enum logic [1:0] {rt = 2'b00, rd = 2'b01, ra = 2'b11} regDst_e;

  typedef enum logic [2:0] {
    aluOut = 3'd0,
    pcLink = 3'd2,
    hi     = 3'd3,
    lo     = 3'd4
  } regData_e;

  typedef enum logic [1:0] {reset, fetch, execute} phase_e;

  typedef struct packed {
    instrClass_e instrClass;
    aluOp_e      aluOp;
    logic        selHi;     // mfhi when set, mflo otherwise
    logic [2:0]  execSteps;
  } decodedInstr_t;

  typedef struct packed {
    phase_e        phase;
    logic [2:0]    step;
    decodedInstr_t instr;
  } seqState_t;

  typedef struct packed {
    logic     pcWrite;
    logic     irWrite;
    logic     aWrite;
    logic     bWrite;
    logic     aluOutWrite;
    logic     regWrite;
    pcSrc_e   pcSrc;
    aluSrcA_e aluSrcA;
    aluSrcB_e aluSrcB;
    aluOp_e   aluOp;
    regDst_e  regDst;
    regData_e regData;
  } ctrlWord_t;

endpackage

// File: hw/stepSequencer.sv
`timescale 1ns/10ps
`include "mipsCtrl_config.svh"

module stepSequencer (
  input  logic                       clk,
  input  logic                       reset_in,
  input  mipsCtrlPkg::decodedInstr_t decoded,
  output mipsCtrlPkg::seqState_t     seq
);

  mipsCtrlPkg::phase_e        phase;
  logic [`STEP_W-1:0]         step;
  mipsCtrlPkg::decodedInstr_t heldInstr;
  logic                       decodeStep;
  logic                       lastExecStep;

  assign decodeStep   = (phase == mipsCtrlPkg::fetch) && (step == `FETCH_DECODE_STEP);
  assign lastExecStep = (step == heldInstr.execSteps - 1'b1);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= mipsCtrlPkg::reset;
      step  <= '0;
    end else begin
      case (phase)
        mipsCtrlPkg::reset: begin
          phase <= mipsCtrlPkg::fetch;
          step  <= '0;
        end
        mipsCtrlPkg::fetch: begin
          if (decodeStep) begin
            step <= '0;
            // Zero-length execute goes straight back to fetch
            if (decoded.execSteps != `EXEC_NONE) begin
              phase <= mipsCtrlPkg::execute;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        mipsCtrlPkg::execute: begin
          if (lastExecStep) begin
            phase <= mipsCtrlPkg::fetch;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          phase <= mipsCtrlPkg::reset;
          step  <= '0;
        end
      endcase
    end
  end

  // Instruction captured at decode
  always_ff @(posedge clk) begin
    if (decodeStep) begin
      heldInstr <= decoded;
    end
  end

  always_comb begin
    seq.phase = phase;
    seq.step  = step;
    // Live decode until execute, then the captured copy
    if (phase == mipsCtrlPkg::execute) begin
      seq.instr = heldInstr;
    end else begin
      seq.instr = decoded;
    end
  end

endmodule

// File: include/mipsCtrl_config.svh
`ifndef MIPS_CTRL_CONFIG_SVH
`define MIPS_CTRL_CONFIG_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

`define STEP_W 3

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03

// R-type funct codes
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_SRA   6'h03
`define FN_SLLV  6'h04
`define FN_SRAV  6'h07
`define FN_JR    6'h08
`define FN_BREAK 6'h0D
`define FN_MFHI  6'h10
`define FN_MFLO  6'h12
`define FN_RTE   6'h13
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_SLT   6'h2A

// Execute lengths per class, in cycles
`define EXEC_ALU_REG   3'd5
`define EXEC_SHIFT_VAR 3'd6
`define EXEC_SHIFT_IMM 3'd5
`define EXEC_JR        3'd5
`define EXEC_BREAK     3'd5
`define EXEC_MOVE_HILO 3'd2
`define EXEC_NONE      3'd0

`define FETCH_DECODE_STEP 3'd2 // Last fetch step

`endif

// File: tests/controlUnitTb.sv
`timescale 1ns/10ps
`include "mipsCtrl_config.svh"

module controlUnitTb;

  logic                   clk;
  logic                   reset_in;
  logic [`OPCODE_W-1:0]   opcode;
  logic [`FUNCT_W-1:0]    funct;
  mipsCtrlPkg::ctrlWord_t ctrl;
  logic                   datapathReset;

  mipsCtrlPkg::ctrlWord_t trace [0:31]; // One word per cycle of an instruction
  int                     period;

  controlUnit controlUnit_inst (
    .clk           (clk),
    .reset_in      (reset_in),
    .opcode        (opcode),
    .funct         (funct),
    .ctrl          (ctrl),
    .datapathReset (datapathReset)
  );

  always #5 clk = ~clk;

  task automatic stopOnError(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout: %s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkCtrl(input mipsCtrlPkg::ctrlWord_t exp, input mipsCtrlPkg::ctrlWord_t act,
                           input string msg);
    if (act !== exp) stopOnError($sformatf("%s ctrl exp %h got %h", msg, exp, act));
  endtask

  task automatic checkAluOp(input mipsCtrlPkg::aluOp_e exp, input mipsCtrlPkg::aluOp_e act,
                            input string msg);
    if (act !== exp) stopOnError($sformatf("%s aluOp exp %s got %s", msg, exp.name(), act.name()));
  endtask

  task automatic checkPeriod(input int exp, input int act, input string msg);
    if (act != exp) stopOnError($sformatf("%s period exp %0d got %0d", msg, exp, act));
  endtask

  task automatic checkBit(input logic exp, input logic act, input string msg);
    if (act !== exp) stopOnError($sformatf("%s exp %b got %b", msg, exp, act));
  endtask

  function automatic mipsCtrlPkg::ctrlWord_t fetchWord();
    mipsCtrlPkg::ctrlWord_t w;
    w = '0;
    w.irWrite     = 1'b1;
    w.aluSrcA     = mipsCtrlPkg::pc;
    w.aluSrcB     = mipsCtrlPkg::four;
    w.aluOp       = mipsCtrlPkg::add;
    w.aluOutWrite = 1'b1;
    return w;
  endfunction

  function automatic mipsCtrlPkg::ctrlWord_t pcWord(input mipsCtrlPkg::pcSrc_e src);
    mipsCtrlPkg::ctrlWord_t w;
    w = '0;
    w.pcWrite = 1'b1;
    w.pcSrc   = src;
    return w;
  endfunction

  function automatic mipsCtrlPkg::ctrlWord_t regWord(input mipsCtrlPkg::ctrlWord_t base,
      input mipsCtrlPkg::regDst_e dst, input mipsCtrlPkg::regData_e data);
    base.regWrite = 1'b1;
    base.regDst   = dst;
    base.regData  = data;
    return base;
  endfunction

  function automatic mipsCtrlPkg::aluOp_e expAluOp(input logic [5:0] fn);
    case (fn)
      `FN_ADD:  return mipsCtrlPkg::add;
      `FN_SUB:  return mipsCtrlPkg::sub;
      `FN_AND:  return mipsCtrlPkg::andOp;
      `FN_SLT:  return mipsCtrlPkg::slt;
      `FN_SLLV: return mipsCtrlPkg::shiftL2;
      `FN_SRAV: return mipsCtrlPkg::shiftRa2;
      `FN_SLL:  return mipsCtrlPkg::shiftL1;
      `FN_SRL:  return mipsCtrlPkg::shiftR;
      default:  return mipsCtrlPkg::shiftRa1;
    endcase
  endfunction

  task automatic waitIrWrite();
    int n;
    n = 0;
    while (!ctrl.irWrite) begin
      if (n == 20) stopOnTimeout("irWrite did not rise within 20 cycles");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  // Loads op/fn at fetch step 2 and records every cycle up to the next fetch
  task automatic runInstr(input logic [5:0] op, input logic [5:0] fn);
    int  n;
    logic done;
    waitIrWrite();
    trace[0] = ctrl;
    @(posedge clk);
    #2;
    trace[1] = ctrl;
    @(posedge clk);
    #1;
    opcode = op;
    funct  = fn;
    #1;
    trace[2] = ctrl;
    n    = 3;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      #2;
      checkBit(1'b0, datapathReset, "datapathReset after reset");
      if (ctrl.irWrite) begin
        done = 1'b1;
      end else begin
        if (n == 20) stopOnTimeout("next irWrite did not arrive within 20 cycles");
        trace[n] = ctrl;
        n++;
      end
    end
    period = n;
    checkCtrl(fetchWord(), trace[0], "fetch step 0");
    checkCtrl('0, trace[1], "fetch step 1");
  endtask

  task automatic shuffle(ref logic [5:0] fns [$]);
    logic [5:0] tmp;
    int         j;
    for (int i = fns.size() - 1; i > 0; i--) begin
      j      = $urandom % (i + 1);
      tmp    = fns[i];
      fns[i] = fns[j];
      fns[j] = tmp;
    end
  endtask

  task automatic testReset();
    reset_in = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      if (i == 7) reset_in = 1'b0;
      #1;
      checkBit(1'b1, datapathReset, "datapathReset in reset");
      checkBit(1'b0, ctrl.pcWrite | ctrl.irWrite | ctrl.aWrite | ctrl.bWrite |
               ctrl.aluOutWrite | ctrl.regWrite, "strobes in reset");
    end
    @(posedge clk);
    #2;
    checkCtrl(fetchWord(), ctrl, "first word after reset");
    checkBit(1'b0, datapathReset, "datapathReset after release");
  endtask

  task automatic testAluReg();
    logic [5:0]             fns [$];
    mipsCtrlPkg::ctrlWord_t w;
    fns = '{`FN_ADD, `FN_AND, `FN_SUB, `FN_SLT};
    shuffle(fns);
    foreach (fns[i]) begin
      runInstr(`OP_RTYPE, fns[i]);
      checkPeriod(8, period, "aluReg");
      checkCtrl(pcWord(mipsCtrlPkg::pcAluOut), trace[2], "aluReg decode");
      checkBit(1'b1, trace[3].aWrite & trace[3].bWrite, "aluReg operand load");
      checkAluOp(expAluOp(fns[i]), trace[4].aluOp, "aluReg exec step 1");
      w         = '0;
      w.aluSrcA = mipsCtrlPkg::regA;
      w.aluSrcB = mipsCtrlPkg::regB;
      w.aluOp   = expAluOp(fns[i]);
      checkCtrl(regWord(w, mipsCtrlPkg::rd, mipsCtrlPkg::aluOut), trace[5], "aluReg exec step 2");
      for (int k = 0; k < period; k++) begin
        if (k != 5) checkBit(1'b0, trace[k].regWrite, $sformatf("aluReg regWrite cycle %0d", k));
      end
    end
  endtask

  task automatic testShifts();
    logic [5:0] fns [$];
    fns = '{`FN_SLLV, `FN_SRAV};
    shuffle(fns);
    foreach (fns[i]) begin
      runInstr(`OP_RTYPE, fns[i]);
      checkPeriod(9, period, "shiftVar");
      checkBit(1'b1, trace[4].aluSrcA == mipsCtrlPkg::regA, "shiftVar aluSrcA regA");
      checkAluOp(expAluOp(fns[i]), trace[6].aluOp, "shiftVar exec step 3");
      checkBit(1'b1, trace[6].regWrite, "shiftVar regWrite");
    end
    fns = '{`FN_SLL, `FN_SRL, `FN_SRA};
    shuffle(fns);
    foreach (fns[i]) begin
      runInstr(`OP_RTYPE, fns[i]);
      checkPeriod(8, period, "shiftImm");
      checkBit(1'b1, trace[4].aluSrcB == mipsCtrlPkg::regB, "shiftImm aluSrcB regB");
      checkAluOp(expAluOp(fns[i]), trace[4].aluOp, "shiftImm exec step 1");
      checkBit(1'b1, trace[5].regWrite, "shiftImm regWrite");
    end
  endtask

  task automatic testControlFlow();
    mipsCtrlPkg::ctrlWord_t w;
    runInstr(`OP_J, 6'($urandom));
    checkPeriod(3, period, "j");
    checkCtrl(pcWord(mipsCtrlPkg::pcJumpTarget), trace[2], "j decode");
    runInstr(`OP_RTYPE, `FN_JR);
    checkPeriod(8, period, "jr");
    w         = pcWord(mipsCtrlPkg::pcAluResult);
    w.aluSrcA = mipsCtrlPkg::regA;
    w.aluOp   = mipsCtrlPkg::passA;
    checkCtrl(w, trace[5], "jr exec step 2");
    runInstr(`OP_RTYPE, `FN_RTE);
    checkPeriod(3, period, "rte");
    checkCtrl(pcWord(mipsCtrlPkg::pcEpc), trace[2], "rte decode");
    runInstr(`OP_RTYPE, `FN_BREAK);
    checkPeriod(8, period, "break");
    w       = fetchWord();
    w.irWrite = 1'b0;
    w.aluOp   = mipsCtrlPkg::sub;
    checkCtrl(w, trace[3], "break exec step 0");
    checkCtrl(pcWord(mipsCtrlPkg::pcAluOut), trace[5], "break exec step 2");
  endtask

  task automatic testDecodeWrites();
    runInstr(`OP_RTYPE, `FN_MFHI);
    checkPeriod(5, period, "mfhi");
    checkCtrl(regWord(pcWord(mipsCtrlPkg::pcAluOut), mipsCtrlPkg::rd, mipsCtrlPkg::hi),
              trace[2], "mfhi decode");
    runInstr(`OP_RTYPE, `FN_MFLO);
    checkPeriod(5, period, "mflo");
    checkCtrl(regWord(pcWord(mipsCtrlPkg::pcAluOut), mipsCtrlPkg::rd, mipsCtrlPkg::lo),
              trace[2], "mflo decode");
    runInstr(`OP_JAL, 6'($urandom));
    checkPeriod(3, period, "jal");
    checkCtrl(regWord(pcWord(mipsCtrlPkg::pcJumpTarget), mipsCtrlPkg::ra, mipsCtrlPkg::pcLink),
              trace[2], "jal decode");
  endtask

  task automatic testUnsupported();
    runInstr(6'h23, 6'($urandom)); // lw encoding
    checkPeriod(3, period, "unsupported");
    checkCtrl(pcWord(mipsCtrlPkg::pcAluOut), trace[2], "unsupported decode");
  endtask

  initial begin
    void'($urandom(32'h38159527));
    clk      = 1'b0;
    reset_in = 1'b1;
    opcode   = '0;
    funct    = '0;
    testReset();
    testAluReg();
    testShifts();
    testControlFlow();
    testDecodeWrites();
    testUnsupported();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: tests/controlUnit_sva.sv
`timescale 1ns/10ps

module controlUnitSva (
  input logic                   clk,
  input logic                   reset_in,
  input mipsCtrlPkg::ctrlWord_t ctrl,
  input logic                   datapathReset
);

  logic anyStrobe;

  assign anyStrobe = ctrl.pcWrite | ctrl.irWrite | ctrl.aWrite | ctrl.bWrite |
                     ctrl.aluOutWrite | ctrl.regWrite;

  quietInReset: assert property (@(posedge clk) datapathReset |-> !anyStrobe)
    else $error("strobe active while datapath is in reset");

  // Fetch is at least three cycles long
  irSpacing: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.irWrite |=> !ctrl.irWrite [*2])
    else $error("irWrite repeated within two cycles");

  pcIrExclusive: assert property (@(posedge clk) disable iff (reset_in)
    !(ctrl.pcWrite && ctrl.irWrite))
    else $error("pcWrite and irWrite together");

  regOperandExclusive: assert property (@(posedge clk) disable iff (reset_in)
    ctrl.regWrite |-> !(ctrl.aWrite || ctrl.bWrite))
    else $error("regWrite with an operand register write");

endmodule

bind controlUnit controlUnitSva sva_inst (
  .clk           (clk),
  .reset_in      (reset_in),
  .ctrl          (ctrl),
  .datapathReset (datapathReset)
);
